// File: src/rob_pkg.sv
package rob_pkg;

  // dispatch and retire width
  localparam int num_super = 2;

  localparam int num_rob  = 16;
  localparam int num_arch = 32;
  localparam int num_phys = 48;

  localparam int rob_idx_w  = $clog2(num_rob);
  localparam int arch_idx_w = $clog2(num_arch);
  localparam int phys_idx_w = $clog2(num_phys);

  typedef logic [rob_idx_w-1:0]  rob_idx_t;
  typedef logic [arch_idx_w-1:0] arch_idx_t;
  typedef logic [phys_idx_w-1:0] phys_idx_t;

  // one reorder buffer slot
  typedef struct packed {
    logic      valid;
    logic      complete;
    logic      halt;
    arch_idx_t dest_idx;
    // tag written by this instruction
    phys_idx_t t_idx;
    // tag it supersedes, freed at retire
    phys_idx_t told_idx;
  } rob_entry_t;

endpackage

// File: src/rob.sv
module rob (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         dispatch_fire,
  input  rob_pkg::arch_idx_t [rob_pkg::num_super-1:0] dest_idx,
  input  logic               [rob_pkg::num_super-1:0] halt,
  input  rob_pkg::phys_idx_t [rob_pkg::num_super-1:0] t_idx_new,
  input  rob_pkg::phys_idx_t [rob_pkg::num_super-1:0] told_idx_new,
  input  logic               [rob_pkg::num_super-1:0] complete_en,
  input  rob_pkg::rob_idx_t  [rob_pkg::num_super-1:0] complete_rob_idx,
  input  logic                                         rollback_en,
  input  rob_pkg::rob_idx_t                            rollback_idx,
  output logic                                         rob_ready,
  output rob_pkg::rob_idx_t  [rob_pkg::num_super-1:0] rob_idx,
  output logic               [rob_pkg::num_super-1:0] retire_en,
  output rob_pkg::arch_idx_t [rob_pkg::num_super-1:0] retire_dest,
  output rob_pkg::phys_idx_t [rob_pkg::num_super-1:0] retire_t_idx,
  output rob_pkg::phys_idx_t [rob_pkg::num_super-1:0] retire_told,
  output logic                                         halt_out,
  output logic                                         recover
);

  typedef enum logic [1:0] {
    st_run,
    st_recover_wait,
    st_recover,
    st_halted
  } state_t;

  rob_pkg::rob_entry_t entries   [rob_pkg::num_rob];
  rob_pkg::rob_entry_t entries_n [rob_pkg::num_rob];

  rob_pkg::rob_idx_t head;
  rob_pkg::rob_idx_t tail;
  rob_pkg::rob_idx_t rollback_q;
  rob_pkg::rob_idx_t [rob_pkg::num_super-1:0] head_idx;
  rob_pkg::rob_idx_t [rob_pkg::num_super-1:0] tail_idx;

  state_t state;
  state_t state_n;

  logic mispredict;
  logic branch_retired;
  logic [rob_pkg::num_super-1:0] slot_free;

  assign head_idx[0] = head;
  assign head_idx[1] = head + 1'b1;
  assign tail_idx[0] = tail;
  assign tail_idx[1] = tail + 1'b1;

  assign rob_idx = tail_idx;

  always_comb begin
    retire_en[0] = entries[head_idx[0]].valid && entries[head_idx[0]].complete &&
                   !rollback_en && state != st_halted;
    // nothing behind a halt may retire with it
    retire_en[1] = entries[head_idx[1]].valid && entries[head_idx[1]].complete &&
                   retire_en[0] && !entries[head_idx[0]].halt;
  end

  always_comb begin
    for (int k = 0; k < rob_pkg::num_super; k++) begin
      retire_dest[k]  = entries[head_idx[k]].dest_idx;
      retire_t_idx[k] = entries[head_idx[k]].t_idx;
      retire_told[k]  = entries[head_idx[k]].told_idx;
    end
  end

  assign halt_out = (retire_en[0] && entries[head_idx[0]].halt) ||
                    (retire_en[1] && entries[head_idx[1]].halt);

  // tail slot counts as free if the head is vacating it this cycle
  always_comb begin
    for (int k = 0; k < rob_pkg::num_super; k++) begin
      slot_free[k] = !entries[tail_idx[k]].valid ||
                     (retire_en[0] && tail_idx[k] == head_idx[0]) ||
                     (retire_en[1] && tail_idx[k] == head_idx[1]);
    end
  end

  assign rob_ready = state == st_run && !rollback_en && (&slot_free);

  assign mispredict = rollback_en && entries[rollback_idx].valid && state != st_halted;
  assign recover    = state == st_recover;

  assign branch_retired = (retire_en[0] && head_idx[0] == rollback_q) ||
                          (retire_en[1] && head_idx[1] == rollback_q);

  always_comb begin
    entries_n = entries;
    for (int k = 0; k < rob_pkg::num_super; k++) begin
      if (complete_en[k]) begin
        entries_n[complete_rob_idx[k]].complete = 1'b1;
      end
    end
    for (int k = 0; k < rob_pkg::num_super; k++) begin
      if (retire_en[k]) begin
        entries_n[head_idx[k]].valid = 1'b0;
      end
    end
    if (dispatch_fire) begin
      for (int k = 0; k < rob_pkg::num_super; k++) begin
        entries_n[tail_idx[k]].valid    = 1'b1;
        // halt has nothing to execute
        entries_n[tail_idx[k]].complete = halt[k];
        entries_n[tail_idx[k]].halt     = halt[k];
        entries_n[tail_idx[k]].dest_idx = dest_idx[k];
        entries_n[tail_idx[k]].t_idx    = t_idx_new[k];
        entries_n[tail_idx[k]].told_idx = told_idx_new[k];
      end
    end
    // flush everything younger than the branch by distance from head
    if (mispredict) begin
      for (int i = 0; i < rob_pkg::num_rob; i++) begin
        if (rob_pkg::rob_idx_t'(i - head) > rob_pkg::rob_idx_t'(rollback_idx - head)) begin
          entries_n[i].valid = 1'b0;
        end
      end
    end
  end

  always_comb begin
    state_n = state;
    case (state)
      st_run, st_recover_wait: begin
        if (halt_out) begin
          state_n = st_halted;
        end else if (mispredict) begin
          state_n = st_recover_wait;
        end else if (state == st_recover_wait && branch_retired) begin
          state_n = st_recover;
        end
      end
      st_recover: state_n = st_run;
      default:    state_n = state;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head       <= '0;
      tail       <= '0;
      rollback_q <= '0;
      state      <= st_run;
      for (int i = 0; i < rob_pkg::num_rob; i++) begin
        entries[i].valid    <= 1'b0;
        entries[i].complete <= 1'b0;
      end
    end else begin
      entries <= entries_n;
      state   <= state_n;
      if (retire_en[1]) begin
        head <= head + 2'd2;
      end else if (retire_en[0]) begin
        head <= head + 1'b1;
      end
      if (mispredict) begin
        tail       <= rollback_idx + 1'b1;
        rollback_q <= rollback_idx;
      end else if (dispatch_fire) begin
        tail <= tail + 2'd2;
      end
    end
  end

  // maps are restored only once nothing is in flight
  a_empty_on_recover: assert property (@(posedge clock) disable iff (reset)
    recover |-> (head == tail && !entries[head].valid));

  for (genvar k = 0; k < rob_pkg::num_super; k++) begin : g_complete_chk
    a_complete_valid: assert property (@(posedge clock) disable iff (reset)
      complete_en[k] |-> entries[complete_rob_idx[k]].valid);
  end

endmodule

// File: src/free_list.sv
module free_list (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         alloc,
  input  logic               [rob_pkg::num_super-1:0] free_en,
  input  rob_pkg::phys_idx_t [rob_pkg::num_super-1:0] free_tag,
  input  logic                                         recover,
  input  logic               [rob_pkg::num_phys-1:0]  arch_used,
  output rob_pkg::phys_idx_t [rob_pkg::num_super-1:0] t_idx,
  output logic                                         avail
);

  // one bit per physical tag where set means free
  logic [rob_pkg::num_phys-1:0] free_vec;
  logic [rob_pkg::num_phys-1:0] free_vec_n;
  logic first_found;

  // two lowest free tags in one scan
  always_comb begin
    first_found = 1'b0;
    avail       = 1'b0;
    t_idx       = '0;
    for (int i = 0; i < rob_pkg::num_phys; i++) begin
      if (free_vec[i] && !first_found) begin
        t_idx[0]    = rob_pkg::phys_idx_t'(i);
        first_found = 1'b1;
      end else if (free_vec[i] && !avail) begin
        t_idx[1] = rob_pkg::phys_idx_t'(i);
        avail    = 1'b1;
      end
    end
  end

  always_comb begin
    free_vec_n = free_vec;
    if (alloc) begin
      free_vec_n[t_idx[0]] = 1'b0;
      free_vec_n[t_idx[1]] = 1'b0;
    end
    for (int k = 0; k < rob_pkg::num_super; k++) begin
      if (free_en[k]) begin
        free_vec_n[free_tag[k]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      // tags above the identity map start free
      free_vec <= {{(rob_pkg::num_phys - rob_pkg::num_arch){1'b1}},
                   {rob_pkg::num_arch{1'b0}}};
    end else if (recover) begin
      free_vec <= ~arch_used;
    end else begin
      free_vec <= free_vec_n;
    end
  end

  // a retired old tag is never already free
  for (genvar k = 0; k < rob_pkg::num_super; k++) begin : g_free_chk
    a_no_double_free: assert property (@(posedge clock) disable iff (reset)
      free_en[k] |-> !free_vec[free_tag[k]]);
  end

endmodule

// File: src/map_table.sv
module map_table (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         rename_en,
  input  rob_pkg::arch_idx_t [rob_pkg::num_super-1:0] dest_idx,
  input  rob_pkg::phys_idx_t [rob_pkg::num_super-1:0] t_idx,
  input  logic                                         recover,
  input  rob_pkg::phys_idx_t [rob_pkg::num_arch-1:0]  arch_map,
  output rob_pkg::phys_idx_t [rob_pkg::num_super-1:0] told_idx
);

  rob_pkg::phys_idx_t [rob_pkg::num_arch-1:0] map_q;

  // second slot sees the first slot's new tag on a shared dest
  always_comb begin
    told_idx[0] = map_q[dest_idx[0]];
    if (dest_idx[1] == dest_idx[0]) begin
      told_idx[1] = t_idx[0];
    end else begin
      told_idx[1] = map_q[dest_idx[1]];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < rob_pkg::num_arch; r++) begin
        map_q[r] <= rob_pkg::phys_idx_t'(r);
      end
    end else if (recover) begin
      map_q <= arch_map;
    end else if (rename_en) begin
      // slot 1 written last so it wins a collision
      map_q[dest_idx[0]] <= t_idx[0];
      map_q[dest_idx[1]] <= t_idx[1];
    end
  end

endmodule

// File: src/arch_map.sv
module arch_map (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic               [rob_pkg::num_super-1:0] retire_en,
  input  rob_pkg::arch_idx_t [rob_pkg::num_super-1:0] retire_dest,
  input  rob_pkg::phys_idx_t [rob_pkg::num_super-1:0] retire_t_idx,
  output rob_pkg::phys_idx_t [rob_pkg::num_arch-1:0]  arch_map,
  output logic               [rob_pkg::num_phys-1:0]  arch_used
);

  // tags held by committed state
  always_comb begin
    arch_used = '0;
    for (int r = 0; r < rob_pkg::num_arch; r++) begin
      arch_used[arch_map[r]] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < rob_pkg::num_arch; r++) begin
        arch_map[r] <= rob_pkg::phys_idx_t'(r);
      end
    end else begin
      // program order within the pair
      for (int k = 0; k < rob_pkg::num_super; k++) begin
        if (retire_en[k]) begin
          arch_map[retire_dest[k]] <= retire_t_idx[k];
        end
      end
    end
  end

endmodule

// File: src/rename_retire_top.sv
module rename_retire_top (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         dispatch_valid,
  input  rob_pkg::arch_idx_t [rob_pkg::num_super-1:0] dest_idx,
  input  logic               [rob_pkg::num_super-1:0] halt,
  input  logic               [rob_pkg::num_super-1:0] complete_en,
  input  rob_pkg::rob_idx_t  [rob_pkg::num_super-1:0] complete_rob_idx,
  input  logic                                         rollback_en,
  input  rob_pkg::rob_idx_t                            rollback_idx,
  output logic                                         dispatch_ready,
  output rob_pkg::rob_idx_t  [rob_pkg::num_super-1:0] rob_idx,
  output rob_pkg::phys_idx_t [rob_pkg::num_super-1:0] t_idx,
  output logic               [rob_pkg::num_super-1:0] retire_en,
  output rob_pkg::arch_idx_t [rob_pkg::num_super-1:0] retire_dest,
  output rob_pkg::phys_idx_t [rob_pkg::num_super-1:0] retire_t_idx,
  output logic                                         halt_out
);

  logic dispatch_fire;
  logic rob_ready;
  logic avail;
  logic recover;

  rob_pkg::phys_idx_t [rob_pkg::num_super-1:0] told_idx;
  rob_pkg::phys_idx_t [rob_pkg::num_super-1:0] retire_told;
  rob_pkg::phys_idx_t [rob_pkg::num_arch-1:0]  committed_map;
  logic               [rob_pkg::num_phys-1:0]  arch_used;

  assign dispatch_ready = rob_ready && avail;
  assign dispatch_fire  = dispatch_valid && dispatch_ready;

  rob rob_i (
    .clock            (clock),
    .reset            (reset),
    .dispatch_fire    (dispatch_fire),
    .dest_idx         (dest_idx),
    .halt             (halt),
    .t_idx_new        (t_idx),
    .told_idx_new     (told_idx),
    .complete_en      (complete_en),
    .complete_rob_idx (complete_rob_idx),
    .rollback_en      (rollback_en),
    .rollback_idx     (rollback_idx),
    .rob_ready        (rob_ready),
    .rob_idx          (rob_idx),
    .retire_en        (retire_en),
    .retire_dest      (retire_dest),
    .retire_t_idx     (retire_t_idx),
    .retire_told      (retire_told),
    .halt_out         (halt_out),
    .recover          (recover)
  );

  free_list free_list_i (
    .clock     (clock),
    .reset     (reset),
    .alloc     (dispatch_fire),
    .free_en   (retire_en),
    .free_tag  (retire_told),
    .recover   (recover),
    .arch_used (arch_used),
    .t_idx     (t_idx),
    .avail     (avail)
  );

  map_table map_table_i (
    .clock     (clock),
    .reset     (reset),
    .rename_en (dispatch_fire),
    .dest_idx  (dest_idx),
    .t_idx     (t_idx),
    .recover   (recover),
    .arch_map  (committed_map),
    .told_idx  (told_idx)
  );

  arch_map arch_map_i (
    .clock        (clock),
    .reset        (reset),
    .retire_en    (retire_en),
    .retire_dest  (retire_dest),
    .retire_t_idx (retire_t_idx),
    .arch_map     (committed_map),
    .arch_used    (arch_used)
  );

endmodule

// File: test/rob_tb.sv
module rob_tb;

  localparam int max_cases      = 64;
  localparam int case_bytes     = 7;
  localparam int timeout_cycles = 50;

  typedef struct packed {
    rob_pkg::arch_idx_t dest;
    rob_pkg::phys_idx_t tag;
    rob_pkg::phys_idx_t told;
    rob_pkg::rob_idx_t  rob;
  } model_entry_t;

  typedef struct packed {
    rob_pkg::arch_idx_t dest;
    rob_pkg::phys_idx_t tag;
    int                 cycle;
  } seen_t;

  logic                                         clock;
  logic                                         reset;
  logic                                         dispatch_valid;
  rob_pkg::arch_idx_t [rob_pkg::num_super-1:0] dest_idx;
  logic               [rob_pkg::num_super-1:0] halt;
  logic               [rob_pkg::num_super-1:0] complete_en;
  rob_pkg::rob_idx_t  [rob_pkg::num_super-1:0] complete_rob_idx;
  logic                                         rollback_en;
  rob_pkg::rob_idx_t                            rollback_idx;
  logic                                         dispatch_ready;
  rob_pkg::rob_idx_t  [rob_pkg::num_super-1:0] rob_idx;
  rob_pkg::phys_idx_t [rob_pkg::num_super-1:0] t_idx;
  logic               [rob_pkg::num_super-1:0] retire_en;
  rob_pkg::arch_idx_t [rob_pkg::num_super-1:0] retire_dest;
  rob_pkg::phys_idx_t [rob_pkg::num_super-1:0] retire_t_idx;
  logic                                         halt_out;

  logic [7:0] cases_mem [0:case_bytes*max_cases-1];

  // reference model state
  model_entry_t                 model_q [$];
  rob_pkg::phys_idx_t           m_arch [rob_pkg::num_arch];
  logic [rob_pkg::num_phys-1:0] m_free;
  rob_pkg::rob_idx_t            m_tail;
  logic                         recover_pending;

  // retirements waiting to be matched against the case file
  seen_t  seen_q [$];
  int     cycle;
  int     last_cycle;
  int     halt_count;
  logic   late_retire;
  int     errors;
  int     checks;
  int     tests;
  int     test_errors;
  logic   timed_out;
  integer seed;

  rename_retire_top dut_i (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic tally(input logic ok, input string what, input int got, input int want);
    checks++;
    if (!ok) begin
      $display("error at %0t: %s is %0d, expected %0d", $time, what, got, want);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_phys(input rob_pkg::phys_idx_t got, want, input string what);
    tally(got === want, what, got, want);
  endtask

  task automatic check_arch(input rob_pkg::arch_idx_t got, want, input string what);
    tally(got === want, what, got, want);
  endtask

  task automatic check_rob(input rob_pkg::rob_idx_t got, want, input string what);
    tally(got === want, what, got, want);
  endtask

  task automatic check_flag(input bit got, want, input string what);
    tally(got === want, what, got, want);
  endtask

  task automatic stop_on_timeout(input string why);
    $display("%s, giving up at %0t", why, $time);
    timed_out = 1'b1;
    errors++;
    test_errors++;
  endtask

  function automatic rob_pkg::phys_idx_t lowest_free(input logic [rob_pkg::num_phys-1:0] vec);
    for (int i = 0; i < rob_pkg::num_phys; i++) begin
      if (vec[i]) return rob_pkg::phys_idx_t'(i);
    end
    return '0;
  endfunction

  // youngest in-flight writer of dest, else the committed tag
  function automatic rob_pkg::phys_idx_t current_tag(input rob_pkg::arch_idx_t dest);
    for (int i = model_q.size() - 1; i >= 0; i--) begin
      if (model_q[i].dest == dest) return model_q[i].tag;
    end
    return m_arch[dest];
  endfunction

  always @(posedge clock) begin
    model_entry_t ent;
    seen_t        s;
    int           keep;
    if (!reset) begin
      cycle++;
      if (rollback_en) begin
        keep = -1;
        for (int i = 0; i < model_q.size(); i++) begin
          if (model_q[i].rob == rollback_idx) keep = i + 1;
        end
        if (keep >= 0) begin
          while (model_q.size() > keep) ent = model_q.pop_back();
          m_tail          = rollback_idx + 1'b1;
          recover_pending = 1'b1;
        end
      end
      if (dispatch_valid && dispatch_ready) begin
        // free tags after recovery are those the committed map does not hold
        if (recover_pending) begin
          m_free = '1;
          for (int r = 0; r < rob_pkg::num_arch; r++) m_free[m_arch[r]] = 1'b0;
          recover_pending = 1'b0;
        end
        for (int k = 0; k < rob_pkg::num_super; k++) begin
          ent.dest = dest_idx[k];
          ent.tag  = lowest_free(m_free);
          ent.told = current_tag(dest_idx[k]);
          ent.rob  = m_tail;
          m_free[ent.tag] = 1'b0;
          check_phys(t_idx[k], ent.tag, "t_idx");
          check_rob(rob_idx[k], ent.rob, "rob_idx");
          model_q.push_back(ent);
          m_tail = m_tail + 1'b1;
        end
      end
      for (int k = 0; k < rob_pkg::num_super; k++) begin
        if (retire_en[k] && model_q.size() == 0) begin
          $display("a retirement at %0t had no outstanding instruction", $time);
          errors++;
          test_errors++;
        end else if (retire_en[k]) begin
          ent = model_q.pop_front();
          check_arch(retire_dest[k], ent.dest, "retire_dest");
          check_phys(retire_t_idx[k], ent.tag, "retire_t_idx");
          m_arch[ent.dest] = ent.tag;
          m_free[ent.told] = 1'b1;
          s.dest  = retire_dest[k];
          s.tag   = retire_t_idx[k];
          s.cycle = cycle;
          seen_q.push_back(s);
          if (halt_count > 0) late_retire = 1'b1;
        end
      end
      if (halt_out) halt_count++;
    end
  end

  task automatic dispatch_pair(input logic [7:0] d0, d1, hmask, tag0, tag1);
    int waited;
    waited = 0;
    @(negedge clock);
    dispatch_valid = 1'b1;
    dest_idx[0]    = d0[4:0];
    dest_idx[1]    = d1[4:0];
    halt           = hmask[1:0];
    @(posedge clock);
    while (!dispatch_ready && waited < timeout_cycles) begin
      waited++;
      @(posedge clock);
    end
    if (!dispatch_ready) begin
      stop_on_timeout("dispatch_ready never went high");
    end else begin
      check_phys(t_idx[0], tag0[5:0], "dispatched tag 0");
      check_phys(t_idx[1], tag1[5:0], "dispatched tag 1");
    end
    @(negedge clock);
    dispatch_valid = 1'b0;
  endtask

  task automatic complete_pair(input logic [7:0] idx0, idx1, mask);
    @(negedge clock);
    complete_en         = mask[1:0];
    complete_rob_idx[0] = idx0[3:0];
    complete_rob_idx[1] = idx1[3:0];
    @(negedge clock);
    complete_en = '0;
    // random gap before the next completion
    repeat ($unsigned($random(seed)) % 3) @(negedge clock);
  endtask

  task automatic rollback_to(input logic [7:0] idx);
    @(negedge clock);
    rollback_en  = 1'b1;
    rollback_idx = idx[3:0];
    @(negedge clock);
    rollback_en = 1'b0;
  endtask

  task automatic expect_retire(input logic [7:0] dest, tag, same);
    int    waited;
    seen_t s;
    waited = 0;
    while (seen_q.size() == 0 && waited < timeout_cycles) begin
      waited++;
      @(negedge clock);
    end
    if (seen_q.size() == 0) begin
      stop_on_timeout("no retirement arrived");
    end else begin
      s = seen_q.pop_front();
      check_arch(s.dest, dest[4:0], "retired dest");
      check_phys(s.tag, tag[5:0], "retired tag");
      if (same[0]) check_flag(s.cycle == last_cycle, 1'b1, "pair retired together");
      last_cycle = s.cycle;
    end
  endtask

  task automatic check_ready(input logic [7:0] want);
    @(posedge clock);
    check_flag(dispatch_ready, want[0], "dispatch_ready");
  endtask

  task automatic check_halt();
    // window for stray retirements
    repeat (20) @(negedge clock);
    check_flag(halt_count == 1, 1'b1, "one halt_out pulse");
    check_flag(late_retire, 1'b0, "retirement after halt");
  endtask

  task automatic finish_test(input int n);
    tests++;
    if (test_errors == 0)
      $display("test %0d passed", n);
    else
      $display("test %0d failed with %0d errors", n, test_errors);
    test_errors = 0;
  endtask

  initial begin
    int         base;
    int         cur_test;
    logic [7:0] op;
    seed             = 32'h2535;
    reset            = 1'b1;
    dispatch_valid   = 1'b0;
    dest_idx         = '0;
    halt             = '0;
    complete_en      = '0;
    complete_rob_idx = '0;
    rollback_en      = 1'b0;
    rollback_idx     = '0;
    timed_out        = 1'b0;
    late_retire      = 1'b0;
    recover_pending  = 1'b0;
    m_tail           = '0;
    for (int i = 0; i < rob_pkg::num_phys; i++) m_free[i] = i >= rob_pkg::num_arch;
    for (int r = 0; r < rob_pkg::num_arch; r++) m_arch[r] = rob_pkg::phys_idx_t'(r);
    $readmemh("test/rob_cases.txt", cases_mem);
    repeat (3) @(negedge clock);
    reset    = 1'b0;
    cur_test = cases_mem[0];
    for (int n = 0; n < max_cases && !timed_out; n++) begin
      base = case_bytes * n;
      op   = cases_mem[base + 1];
      if ($isunknown(op) || op == 8'h00) break;
      if (cases_mem[base] != cur_test) begin
        finish_test(cur_test);
        cur_test = cases_mem[base];
      end
      case (op)
        8'h01: dispatch_pair(cases_mem[base + 2], cases_mem[base + 3], cases_mem[base + 4],
                             cases_mem[base + 5], cases_mem[base + 6]);
        8'h02: complete_pair(cases_mem[base + 2], cases_mem[base + 3], cases_mem[base + 4]);
        8'h03: rollback_to(cases_mem[base + 2]);
        8'h04: expect_retire(cases_mem[base + 5], cases_mem[base + 6], cases_mem[base + 4]);
        8'h05: check_ready(cases_mem[base + 2]);
        8'h06: check_halt();
        default: begin
          $display("case %0d has an unknown opcode %0h", n, op);
          errors++;
        end
      endcase
    end
    finish_test(cur_test);
    if (seen_q.size() != 0) begin
      $display("%0d retirements were not expected by the case file", seen_q.size());
      errors++;
    end
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

// File: test/rob_cases.txt
// test op a b c e0 e1, op 1 dispatch dests a b, halt mask c, tags e0 e1; op 2 complete rob a b mask c
// op 3 rollback rob a; op 4 retire dest e0 tag e1, c set when same cycle; op 5 ready a; op 6 halt
01 01 01 02 00 20 21
01 01 03 04 00 22 23
02 02 03 02 03 00 00
02 02 01 00 03 00 00
02 04 00 00 00 01 20
02 04 00 00 01 02 21
02 04 00 00 00 03 22
02 04 00 00 01 04 23
03 01 05 06 00 01 02
03 02 04 05 03 00 00
03 04 00 00 00 05 01
03 04 00 00 01 06 02
04 01 07 08 00 03 04
04 01 09 0a 00 05 06
04 01 0b 0c 00 24 25
04 01 0d 0e 00 26 27
04 01 0f 10 00 28 29
04 01 11 12 00 2a 2b
04 01 13 14 00 2c 2d
04 01 15 16 00 2e 2f
04 05 00 00 00 00 00
04 02 06 00 01 00 00
04 02 07 00 01 00 00
04 04 00 00 00 07 03
04 04 00 00 00 08 04
04 05 01 00 00 00 00
05 03 08 00 00 00 00
05 05 00 00 00 00 00
05 02 08 00 01 00 00
05 04 00 00 00 09 05
05 01 01 02 00 06 07
05 02 09 0a 03 00 00
05 04 00 00 00 01 06
05 04 00 00 01 02 07
06 01 03 04 02 08 09
06 01 05 06 00 20 21
06 02 0d 0e 03 00 00
06 02 0b 00 01 00 00
06 04 00 00 00 03 08
06 04 00 00 01 04 09
06 05 00 00 00 00 00
06 06 00 00 00 00 00

// File: src.f
src/rob_pkg.sv
src/rob.sv
src/free_list.sv
src/map_table.sv
src/arch_map.sv
src/rename_retire_top.sv
test/rob_tb.sv
